// File: design/pa_pkg.sv
package pa_pkg;

    // Screen coordinates and depth
    localparam int COORD_W  = 12;
    localparam int DEPTH_W  = 12;   // Unsigned Q0.12
    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 320;

    // Buffer depths
    localparam int MAX_TRIS  = 256;
    localparam int MAX_VERTS = 256;

    localparam int TRI_IDX_W = $clog2(MAX_TRIS);
    localparam int VTX_IDX_W = $clog2(MAX_VERTS);

    localparam int VTX_W = 2 * COORD_W + DEPTH_W + 1;

    typedef logic signed [COORD_W-1:0]     coord_t;
    typedef logic        [DEPTH_W-1:0]     depth_t;
    typedef logic        [TRI_IDX_W:0]     tri_idx_t;   // Holds a count of MAX_TRIS
    typedef logic        [VTX_IDX_W-1:0]   vtx_idx_t;
    typedef logic        [3*VTX_IDX_W-1:0] idx_word_t;  // Index 0 in the low bits
    typedef logic        [VTX_W-1:0]       vtx_word_t;

    // Vertex record layout, x at the bottom and the invalid flag on top
    localparam int VTX_X_LSB   = 0;
    localparam int VTX_Y_LSB   = VTX_X_LSB + COORD_W;
    localparam int VTX_Z_LSB   = VTX_Y_LSB + COORD_W;
    localparam int VTX_INV_BIT = VTX_Z_LSB + DEPTH_W;

    typedef enum logic [1:0] {
        PA_IDLE,
        PA_RUN,
        PA_DRAIN,
        PA_DONE
    } pa_state_t;

endpackage

// File: design/geom_rd_if.sv
interface geom_rd_if;

    // Index buffer read port
    logic                         idx_rd_en;
    logic [pa_pkg::TRI_IDX_W-1:0] idx_addr;
    pa_pkg::idx_word_t            idx_data;

    // Vertex buffer, three reads under one enable
    logic                         vtx_rd_en;
    pa_pkg::vtx_idx_t             vtx_addr [3];
    pa_pkg::vtx_word_t            vtx_data [3];

    modport fetch (
        output idx_rd_en,
        output idx_addr,
        input  idx_data,
        output vtx_rd_en,
        output vtx_addr,
        input  vtx_data
    );

    modport idx_mem (
        input  idx_rd_en,
        input  idx_addr,
        output idx_data
    );

    modport vtx_mem (
        input  vtx_rd_en,
        input  vtx_addr,
        output vtx_data
    );

endinterface

// File: design/index_buffer.sv
module index_buffer (
    input  logic                         clk,

    // Host write port
    input  logic                         i_wr_en,
    input  logic [pa_pkg::TRI_IDX_W-1:0] i_wr_addr,
    input  pa_pkg::idx_word_t            i_wr_data,

    geom_rd_if.idx_mem                   rd
);

    // One entry per triangle
    pa_pkg::idx_word_t mem [pa_pkg::MAX_TRIS];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Registered read, data holds while the enable is low
    always_ff @(posedge clk) begin
        if (rd.idx_rd_en) begin
            rd.idx_data <= mem[rd.idx_addr];
        end
    end

endmodule

// File: design/vertex_buffer.sv
module vertex_buffer (
    input  logic              clk,

    // Host write port
    input  logic              i_wr_en,
    input  pa_pkg::vtx_idx_t  i_wr_addr,
    input  pa_pkg::vtx_word_t i_wr_data,

    geom_rd_if.vtx_mem        rd
);

    pa_pkg::vtx_word_t mem [pa_pkg::MAX_VERTS];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Three read ports share one enable so a whole triangle comes back at once
    for (genvar p = 0; p < 3; p++) begin : g_rd_port
        always_ff @(posedge clk) begin
            if (rd.vtx_rd_en) begin
                rd.vtx_data[p] <= mem[rd.vtx_addr[p]];
            end
        end
    end

endmodule

// File: design/bounding_box.sv
module bounding_box (
    input  pa_pkg::coord_t i_x0,
    input  pa_pkg::coord_t i_y0,
    input  pa_pkg::coord_t i_x1,
    input  pa_pkg::coord_t i_y1,
    input  pa_pkg::coord_t i_x2,
    input  pa_pkg::coord_t i_y2,

    output pa_pkg::coord_t o_min_x,
    output pa_pkg::coord_t o_min_y,
    output pa_pkg::coord_t o_max_x,
    output pa_pkg::coord_t o_max_y,
    output logic           o_on_screen
);

    pa_pkg::coord_t x_lim;
    pa_pkg::coord_t y_lim;
    pa_pkg::coord_t raw_min_x;
    pa_pkg::coord_t raw_max_x;
    pa_pkg::coord_t raw_min_y;
    pa_pkg::coord_t raw_max_y;

    function automatic pa_pkg::coord_t min3(input pa_pkg::coord_t a, input pa_pkg::coord_t b,
                                            input pa_pkg::coord_t c);
        pa_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic pa_pkg::coord_t max3(input pa_pkg::coord_t a, input pa_pkg::coord_t b,
                                            input pa_pkg::coord_t c);
        pa_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Limit to 0 .. hi
    function automatic pa_pkg::coord_t clamp(input pa_pkg::coord_t v, input pa_pkg::coord_t hi);
        if (v < 0) begin
            return '0;
        end
        return (v > hi) ? hi : v;
    endfunction

    assign x_lim = pa_pkg::coord_t'(pa_pkg::SCREEN_W - 1);   // Last pixel column
    assign y_lim = pa_pkg::coord_t'(pa_pkg::SCREEN_H - 1);

    assign raw_min_x = min3(i_x0, i_x1, i_x2);
    assign raw_max_x = max3(i_x0, i_x1, i_x2);
    assign raw_min_y = min3(i_y0, i_y1, i_y2);
    assign raw_max_y = max3(i_y0, i_y1, i_y2);

    assign o_min_x = clamp(raw_min_x, x_lim);
    assign o_max_x = clamp(raw_max_x, x_lim);
    assign o_min_y = clamp(raw_min_y, y_lim);
    assign o_max_y = clamp(raw_max_y, y_lim);

    // Overlap test on the unclamped box
    assign o_on_screen = (raw_max_x >= 0) && (raw_min_x <= x_lim) &&
                         (raw_max_y >= 0) && (raw_min_y <= y_lim);

endmodule

// File: design/primitive_assembler.sv
module primitive_assembler (
    input  logic             clk,
    input  logic             rstn,

    input  logic             i_start,
    input  pa_pkg::tri_idx_t i_num_tris,
    output logic             o_busy,
    output logic             o_done,

    geom_rd_if.fetch         rd,

    // Output triangle, valid/ready
    output logic             o_tri_valid,
    input  logic             i_tri_ready,
    output pa_pkg::coord_t   o_v0_x,
    output pa_pkg::coord_t   o_v0_y,
    output pa_pkg::depth_t   o_v0_z,
    output pa_pkg::coord_t   o_v1_x,
    output pa_pkg::coord_t   o_v1_y,
    output pa_pkg::depth_t   o_v1_z,
    output pa_pkg::coord_t   o_v2_x,
    output pa_pkg::coord_t   o_v2_y,
    output pa_pkg::depth_t   o_v2_z,
    output pa_pkg::coord_t   o_bb_min_x,
    output pa_pkg::coord_t   o_bb_min_y,
    output pa_pkg::coord_t   o_bb_max_x,
    output pa_pkg::coord_t   o_bb_max_y
);

    pa_pkg::pa_state_t state;
    pa_pkg::pa_state_t state_nxt;

    pa_pkg::tri_idx_t  num_tris;
    pa_pkg::tri_idx_t  issue_cnt;

    logic              advance;
    logic              issue;
    logic              b_vld;       // Index data at stage B
    logic              c_vld;       // Vertex data at stage C
    logic              pipe_empty;
    logic              keep;

    pa_pkg::coord_t    v_x   [3];
    pa_pkg::coord_t    v_y   [3];
    pa_pkg::depth_t    v_z   [3];
    logic              v_inv [3];

    pa_pkg::coord_t    bb_min_x;
    pa_pkg::coord_t    bb_min_y;
    pa_pkg::coord_t    bb_max_x;
    pa_pkg::coord_t    bb_max_y;
    logic              bb_on_screen;

    // Whole pipeline moves only when the output slot frees up
    assign advance    = !o_tri_valid || i_tri_ready;
    assign issue      = (state == pa_pkg::PA_RUN) && (issue_cnt != num_tris) && advance;
    assign pipe_empty = !b_vld && !c_vld && !o_tri_valid;

    assign o_busy = (state != pa_pkg::PA_IDLE);
    assign o_done = (state == pa_pkg::PA_DONE);

    // Stage A
    assign rd.idx_rd_en = issue;
    assign rd.idx_addr  = issue_cnt[pa_pkg::TRI_IDX_W-1:0];

    // Stage B
    assign rd.vtx_rd_en = b_vld && advance;
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            rd.vtx_addr[i] = rd.idx_data[i*pa_pkg::VTX_IDX_W +: pa_pkg::VTX_IDX_W];
        end
    end

    // Stage C unpack
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            v_x[i]   = rd.vtx_data[i][pa_pkg::VTX_X_LSB +: pa_pkg::COORD_W];
            v_y[i]   = rd.vtx_data[i][pa_pkg::VTX_Y_LSB +: pa_pkg::COORD_W];
            v_z[i]   = rd.vtx_data[i][pa_pkg::VTX_Z_LSB +: pa_pkg::DEPTH_W];
            v_inv[i] = rd.vtx_data[i][pa_pkg::VTX_INV_BIT];
        end
    end

    bounding_box bb_inst (
        .i_x0        (v_x[0]),
        .i_y0        (v_y[0]),
        .i_x1        (v_x[1]),
        .i_y1        (v_y[1]),
        .i_x2        (v_x[2]),
        .i_y2        (v_y[2]),
        .o_min_x     (bb_min_x),
        .o_min_y     (bb_min_y),
        .o_max_x     (bb_max_x),
        .o_max_y     (bb_max_y),
        .o_on_screen (bb_on_screen)
    );

    assign keep = !(v_inv[0] || v_inv[1] || v_inv[2]) && bb_on_screen;

    always_comb begin
        state_nxt = state;
        case (state)
            pa_pkg::PA_IDLE:  if (i_start) state_nxt = pa_pkg::PA_RUN;
            pa_pkg::PA_RUN:   if (issue_cnt == num_tris) state_nxt = pa_pkg::PA_DRAIN;
            pa_pkg::PA_DRAIN: if (pipe_empty) state_nxt = pa_pkg::PA_DONE;
            pa_pkg::PA_DONE:  state_nxt = pa_pkg::PA_IDLE;
            default:          state_nxt = pa_pkg::PA_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= pa_pkg::PA_IDLE;
            num_tris  <= '0;
            issue_cnt <= '0;
            b_vld     <= 1'b0;
            c_vld     <= 1'b0;
            o_tri_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == pa_pkg::PA_IDLE && i_start) begin
                num_tris  <= i_num_tris;
                issue_cnt <= '0;
            end else if (issue) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (advance) begin
                b_vld       <= issue;
                c_vld       <= b_vld;
                o_tri_valid <= c_vld && keep;   // Culled triangles leave a gap
            end
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (advance && c_vld && keep) begin
            o_v0_x     <= v_x[0];
            o_v0_y     <= v_y[0];
            o_v0_z     <= v_z[0];
            o_v1_x     <= v_x[1];
            o_v1_y     <= v_y[1];
            o_v1_z     <= v_z[1];
            o_v2_x     <= v_x[2];
            o_v2_y     <= v_y[2];
            o_v2_z     <= v_z[2];
            o_bb_min_x <= bb_min_x;
            o_bb_min_y <= bb_min_y;
            o_bb_max_x <= bb_max_x;
            o_bb_max_y <= bb_max_y;
        end
    end

endmodule

// File: design/pa_top.sv
module pa_top (
    input  logic                         clk,
    input  logic                         rstn,

    input  logic                         i_start,
    input  pa_pkg::tri_idx_t             i_num_tris,

    // Host loading, only while idle
    input  logic                         i_idx_wr_en,
    input  logic [pa_pkg::TRI_IDX_W-1:0] i_idx_wr_addr,
    input  pa_pkg::idx_word_t            i_idx_wr_data,
    input  logic                         i_vtx_wr_en,
    input  pa_pkg::vtx_idx_t             i_vtx_wr_addr,
    input  pa_pkg::vtx_word_t            i_vtx_wr_data,

    output logic                         o_busy,
    output logic                         o_done,

    output logic                         o_tri_valid,
    input  logic                         i_tri_ready,
    output pa_pkg::coord_t               o_v0_x,
    output pa_pkg::coord_t               o_v0_y,
    output pa_pkg::depth_t               o_v0_z,
    output pa_pkg::coord_t               o_v1_x,
    output pa_pkg::coord_t               o_v1_y,
    output pa_pkg::depth_t               o_v1_z,
    output pa_pkg::coord_t               o_v2_x,
    output pa_pkg::coord_t               o_v2_y,
    output pa_pkg::depth_t               o_v2_z,
    output pa_pkg::coord_t               o_bb_min_x,
    output pa_pkg::coord_t               o_bb_min_y,
    output pa_pkg::coord_t               o_bb_max_x,
    output pa_pkg::coord_t               o_bb_max_y
);

    geom_rd_if rd_bus ();

    index_buffer idx_buf_inst (
        .clk       (clk),
        .i_wr_en   (i_idx_wr_en),
        .i_wr_addr (i_idx_wr_addr),
        .i_wr_data (i_idx_wr_data),
        .rd        (rd_bus.idx_mem)
    );

    vertex_buffer vtx_buf_inst (
        .clk       (clk),
        .i_wr_en   (i_vtx_wr_en),
        .i_wr_addr (i_vtx_wr_addr),
        .i_wr_data (i_vtx_wr_data),
        .rd        (rd_bus.vtx_mem)
    );

    primitive_assembler pa_inst (
        .clk         (clk),
        .rstn        (rstn),
        .i_start     (i_start),
        .i_num_tris  (i_num_tris),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .rd          (rd_bus.fetch),
        .o_tri_valid (o_tri_valid),
        .i_tri_ready (i_tri_ready),
        .o_v0_x      (o_v0_x),
        .o_v0_y      (o_v0_y),
        .o_v0_z      (o_v0_z),
        .o_v1_x      (o_v1_x),
        .o_v1_y      (o_v1_y),
        .o_v1_z      (o_v1_z),
        .o_v2_x      (o_v2_x),
        .o_v2_y      (o_v2_y),
        .o_v2_z      (o_v2_z),
        .o_bb_min_x  (o_bb_min_x),
        .o_bb_min_y  (o_bb_min_y),
        .o_bb_max_x  (o_bb_max_x),
        .o_bb_max_y  (o_bb_max_y)
    );

endmodule

// File: testbench/tb_pa_top.sv
module tb_pa_top;

    localparam int NUM_VERTS = 64;   // Vertex slots used by the tests
    localparam int N_FULL    = 48;
    localparam int N_CULL    = 48;
    localparam int N_CLAMP   = 48;
    localparam int N_BP      = 64;
    localparam int N_BUSY    = 24;
    localparam int TOTAL_TRIS     = N_FULL + N_CULL + N_CLAMP + N_BP + N_BUSY;
    localparam int TIMEOUT_CYCLES = TOTAL_TRIS * 4 + 200;

    typedef logic [10*pa_pkg::COORD_W+3*pa_pkg::DEPTH_W-1:0] out_t;

    logic              clk;
    logic              rstn;
    logic              i_start;
    pa_pkg::tri_idx_t  i_num_tris;
    logic              i_idx_wr_en;
    logic [pa_pkg::TRI_IDX_W-1:0] i_idx_wr_addr;
    pa_pkg::idx_word_t i_idx_wr_data;
    logic              i_vtx_wr_en;
    pa_pkg::vtx_idx_t  i_vtx_wr_addr;
    pa_pkg::vtx_word_t i_vtx_wr_data;
    logic              o_busy;
    logic              o_done;
    logic              o_tri_valid;
    logic              i_tri_ready;
    pa_pkg::coord_t    o_v0_x;
    pa_pkg::coord_t    o_v0_y;
    pa_pkg::depth_t    o_v0_z;
    pa_pkg::coord_t    o_v1_x;
    pa_pkg::coord_t    o_v1_y;
    pa_pkg::depth_t    o_v1_z;
    pa_pkg::coord_t    o_v2_x;
    pa_pkg::coord_t    o_v2_y;
    pa_pkg::depth_t    o_v2_z;
    pa_pkg::coord_t    o_bb_min_x;
    pa_pkg::coord_t    o_bb_min_y;
    pa_pkg::coord_t    o_bb_max_x;
    pa_pkg::coord_t    o_bb_max_y;
    out_t              dut_out;

    // Reference copies of both buffers
    pa_pkg::idx_word_t idx_m [pa_pkg::MAX_TRIS];
    pa_pkg::vtx_word_t vtx_m [pa_pkg::MAX_VERTS];
    out_t              exp_q [$];

    string cur_test = "reset";
    int    errors   = 0;
    int    passed   = 0;
    int    failed   = 0;
    int    xfer_cnt = 0;
    int    done_cnt = 0;
    int    cycles   = 0;
    bit    counting = 1'b0;
    bit    random_ready = 1'b0;

    pa_top pa_top_inst (.*);

    assign dut_out = {o_v0_x, o_v0_y, o_v0_z, o_v1_x, o_v1_y, o_v1_z, o_v2_x, o_v2_y, o_v2_z,
                      o_bb_min_x, o_bb_min_y, o_bb_max_x, o_bb_max_y};

    always #10 clk = ~clk;

    task automatic note_error(input string msg);
        errors++;
        $display("error in %s: %s", cur_test, msg);
    endtask

    function automatic int smallest(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic int largest(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    function automatic int limit(input int v, input int hi);
        if (v < 0) begin
            return 0;
        end
        return (v > hi) ? hi : v;
    endfunction

    // Expected output word for triangle t, keep low if culled
    function automatic out_t model_tri(input int t, output bit keep);
        pa_pkg::idx_word_t iw;
        pa_pkg::vtx_word_t w;
        pa_pkg::coord_t    cx [3];
        pa_pkg::coord_t    cy [3];
        pa_pkg::depth_t    cz [3];
        bit                inv;
        int                lo_x;
        int                hi_x;
        int                lo_y;
        int                hi_y;
        iw  = idx_m[t];
        inv = 1'b0;
        for (int i = 0; i < 3; i++) begin
            w     = vtx_m[iw[i*pa_pkg::VTX_IDX_W +: pa_pkg::VTX_IDX_W]];
            cx[i] = w[pa_pkg::VTX_X_LSB +: pa_pkg::COORD_W];
            cy[i] = w[pa_pkg::VTX_Y_LSB +: pa_pkg::COORD_W];
            cz[i] = w[pa_pkg::VTX_Z_LSB +: pa_pkg::DEPTH_W];
            inv   = inv | w[pa_pkg::VTX_INV_BIT];
        end
        lo_x = smallest(cx[0], cx[1], cx[2]);
        hi_x = largest(cx[0], cx[1], cx[2]);
        lo_y = smallest(cy[0], cy[1], cy[2]);
        hi_y = largest(cy[0], cy[1], cy[2]);
        keep = !inv && hi_x >= 0 && lo_x <= pa_pkg::SCREEN_W - 1 &&
               hi_y >= 0 && lo_y <= pa_pkg::SCREEN_H - 1;
        return {cx[0], cy[0], cz[0], cx[1], cy[1], cz[1], cx[2], cy[2], cz[2],
                pa_pkg::coord_t'(limit(lo_x, pa_pkg::SCREEN_W - 1)),
                pa_pkg::coord_t'(limit(lo_y, pa_pkg::SCREEN_H - 1)),
                pa_pkg::coord_t'(limit(hi_x, pa_pkg::SCREEN_W - 1)),
                pa_pkg::coord_t'(limit(hi_y, pa_pkg::SCREEN_H - 1))};
    endfunction

    // Mostly inside the widened window, sometimes far off screen
    function automatic int rand_coord(input int off_pct, input int spread, input int span);
        if ($urandom_range(99) < off_pct) begin
            if ($urandom_range(1)) begin
                return -int'($urandom_range(800, 1));
            end
            return span + int'($urandom_range(800, 0));
        end
        return int'($urandom_range(span - 1 + 2 * spread, 0)) - spread;
    endfunction

    task automatic load_data(input int n, input int off_pct, input int spread, input int inv_pct);
        pa_pkg::vtx_word_t w;
        pa_pkg::idx_word_t iw;
        int                count;
        count = (n > NUM_VERTS) ? n : NUM_VERTS;
        for (int i = 0; i < count; i++) begin
            w = '0;
            w[pa_pkg::VTX_X_LSB +: pa_pkg::COORD_W] =
                pa_pkg::coord_t'(rand_coord(off_pct, spread, pa_pkg::SCREEN_W));
            w[pa_pkg::VTX_Y_LSB +: pa_pkg::COORD_W] =
                pa_pkg::coord_t'(rand_coord(off_pct, spread, pa_pkg::SCREEN_H));
            w[pa_pkg::VTX_Z_LSB +: pa_pkg::DEPTH_W] = pa_pkg::depth_t'($urandom);
            w[pa_pkg::VTX_INV_BIT] = ($urandom_range(99) < inv_pct);
            for (int k = 0; k < 3; k++) begin
                iw[k*pa_pkg::VTX_IDX_W +: pa_pkg::VTX_IDX_W] = $urandom_range(NUM_VERTS - 1, 0);
            end
            if (i < NUM_VERTS) vtx_m[i] = w;
            if (i < n) idx_m[i] = iw;
            @(posedge clk);
            i_vtx_wr_en   <= (i < NUM_VERTS);
            i_vtx_wr_addr <= pa_pkg::vtx_idx_t'(i);
            i_vtx_wr_data <= w;
            i_idx_wr_en   <= (i < n);
            i_idx_wr_addr <= i[pa_pkg::TRI_IDX_W-1:0];
            i_idx_wr_data <= iw;
        end
        @(posedge clk);
        i_vtx_wr_en <= 1'b0;
        i_idx_wr_en <= 1'b0;
    endtask

    task automatic run_test(input string name, input int n, input bit rnd_ready,
                            input bit restart);
        int   err_before;
        int   n_exp;
        out_t exp_val;
        bit   keep;
        err_before = errors;
        cur_test   = name;
        exp_q.delete();
        for (int t = 0; t < n; t++) begin
            exp_val = model_tri(t, keep);
            if (keep) exp_q.push_back(exp_val);
        end
        n_exp        = exp_q.size();
        xfer_cnt     = 0;
        done_cnt     = 0;
        random_ready = rnd_ready;
        counting     = 1'b1;
        @(posedge clk);
        i_start    <= 1'b1;
        i_num_tris <= pa_pkg::tri_idx_t'(n);
        @(posedge clk);
        i_start <= 1'b0;
        if (restart) begin
            repeat (3) @(posedge clk);
            if (!o_busy) note_error("DUT went idle before the second start");
            i_start    <= 1'b1;   // Must be ignored
            i_num_tris <= pa_pkg::tri_idx_t'(n + 7);
            @(posedge clk);
            i_start <= 1'b0;
        end
        while (!o_done) @(posedge clk);
        if (exp_q.size() != 0) begin
            note_error($sformatf("o_done came with %0d triangles still missing", exp_q.size()));
        end
        if (xfer_cnt != n_exp) begin
            errors++;
            $display("mismatch test=%s expected=%0d actual=%0d transfers", name, n_exp, xfer_cnt);
        end
        repeat (4) @(posedge clk);
        if (done_cnt != 1) note_error($sformatf("o_done pulsed %0d times", done_cnt));
        if (o_busy) note_error("o_busy still high after o_done");
        counting     = 1'b0;
        random_ready = 1'b0;
        if (errors == err_before) passed++;
        else failed++;
        $display("test %-12s tris %0d transfers %0d errors %0d", name, n, xfer_cnt,
                 errors - err_before);
    endtask

    always @(posedge clk) begin
        i_tri_ready <= random_ready ? 1'($urandom_range(1)) : 1'b1;
    end

    // Transfer point check against the model queue
    always @(posedge clk) begin : xfer_check
        out_t expected;
        if (rstn && o_tri_valid && i_tri_ready) begin
            xfer_cnt++;
            if (exp_q.size() == 0) begin
                note_error("transfer with no triangle expected");
            end else begin
                expected = exp_q.pop_front();
                if (expected !== dut_out) begin
                    errors++;
                    $display("mismatch test=%s expected=%h actual=%h", cur_test, expected,
                             dut_out);
                end
            end
        end
        if (rstn && o_done) done_cnt++;
    end

    always @(posedge clk) begin
        if (counting) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    end

    a_reset_vals: assert property (@(posedge clk)
        $rose(rstn) |-> !o_tri_valid && !o_done && !o_busy)
        else note_error("outputs not low after reset");

    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_tri_valid && !i_tri_ready |=> o_tri_valid && $stable(dut_out))
        else note_error("o_tri_valid dropped or triangle data changed before transfer");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        o_done |=> !o_done && !o_busy)
        else note_error("o_done longer than one cycle or o_busy high after it");

    a_done_empty: assert property (@(posedge clk) disable iff (!rstn) o_done |-> !o_tri_valid)
        else note_error("o_done while a triangle waits at the output");

    initial begin
        void'($urandom(32'h91ef));
        clk           = 1'b0;
        rstn          = 1'b0;
        i_start       = 1'b0;
        i_num_tris    = '0;
        i_idx_wr_en   = 1'b0;
        i_idx_wr_addr = '0;
        i_idx_wr_data = '0;
        i_vtx_wr_en   = 1'b0;
        i_vtx_wr_addr = '0;
        i_vtx_wr_data = '0;
        i_tri_ready   = 1'b1;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        load_data(N_FULL, 10, 0, 8);
        run_test("full_pass", N_FULL, 1'b0, 1'b0);
        load_data(N_CULL, 45, 0, 30);   // Heavy culling
        run_test("culling", N_CULL, 1'b0, 1'b0);
        load_data(N_CLAMP, 0, 160, 0);  // Boxes cross the screen edges
        run_test("clamping", N_CLAMP, 1'b0, 1'b0);
        load_data(N_BP, 15, 40, 10);
        run_test("backpressure", N_BP, 1'b1, 1'b0);
        run_test("zero_count", 0, 1'b0, 1'b0);
        load_data(N_BUSY, 10, 20, 10);
        run_test("start_busy", N_BUSY, 1'b1, 1'b1);

        $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
design/pa_pkg.sv
design/geom_rd_if.sv
design/index_buffer.sv
design/vertex_buffer.sv
design/bounding_box.sv
design/primitive_assembler.sv
design/pa_top.sv
testbench/tb_pa_top.sv

// File: Bender.yml
package:
  name: pa_top

sources:
  - design/pa_pkg.sv
  - design/geom_rd_if.sv
  - design/index_buffer.sv
  - design/vertex_buffer.sv
  - design/bounding_box.sv
  - design/primitive_assembler.sv
  - design/pa_top.sv
  - target: test
    files:
      - testbench/tb_pa_top.sv
